//--- include/integrity_params.svh
// OBI integrity monitor parameters
// Port count, bus widths and counter sizes for the packages and RTL

`ifndef INTEGRITY_PARAMS_SVH
`define INTEGRITY_PARAMS_SVH

// Number of monitored OBI ports
`define OBI_NUM_PORTS 2
// Response data width
`define OBI_DATA_W 32
// Four byte-lane parities plus err
`define OBI_RCHK_W 5
// Highest legal number of granted requests awaiting rvalid
`define OBI_MAX_OUTST 2
// Outstanding counter must hold 0 .. OBI_MAX_OUTST
`define OBI_OUTST_W ($clog2(`OBI_MAX_OUTST + 1))
// Saturating fault counter
`define FAULT_CNT_W 8
// Port index, at least one bit even for a single port
`define PORT_ID_W ((`OBI_NUM_PORTS > 1) ? $clog2(`OBI_NUM_PORTS) : 1)

`endif

//--- rtl/obi_pkg.sv
// OBI response-side sample type
// One port's handshake, parity and response signals for one cycle

`include "integrity_params.svh"

package obi_pkg;

    // ----------------------------------------------------------------------
    // Per-port sample
    // ----------------------------------------------------------------------

    // Request handshake and response channel of one OBI port
    typedef struct packed {
        logic                   req;
        logic                   gnt;
        // Should always be ~gnt
        logic                   gntpar;
        logic                   rvalid;
        // Should always be ~rvalid
        logic                   rvalidpar;
        logic [`OBI_DATA_W-1:0] rdata;
        logic                   err;
        // Byte parities of rdata in bits 0..3, err in bit 4
        logic [`OBI_RCHK_W-1:0] rchk;
    } obi_sample_t;

    // Quiet bus value
    // No handshake, parity lines are the inverse of zero gnt and rvalid,
    // rchk of all-zero data and zero err is zero
    localparam obi_sample_t OBI_SAMPLE_IDLE = '{
        req:       1'b0,
        gnt:       1'b0,
        gntpar:    1'b1,
        rvalid:    1'b0,
        rvalidpar: 1'b1,
        rdata:     '0,
        err:       1'b0,
        rchk:      '0
    };

endpackage

//--- rtl/alert_pkg.sv
// Alert and fault reporting types
// Fault kinds, per-port check result and the sticky alert status

`include "integrity_params.svh"

package alert_pkg;

    // ----------------------------------------------------------------------
    // Fault classification
    // ----------------------------------------------------------------------

    // Encoded in rising priority, PROTOCOL wins over all others
    typedef enum logic [2:0] {
        FAULT_NONE      = 3'd0,
        FAULT_GNTPAR    = 3'd1,
        FAULT_RVALIDPAR = 3'd2,
        FAULT_RCHK      = 3'd3,
        FAULT_PROTOCOL  = 3'd4
    } fault_kind_e;

    // One port's verdict for one sample
    typedef struct packed {
        fault_kind_e kind;
        // Clean response carrying err, only meaningful with kind NONE
        logic        err_resp;
    } port_fault_t;

    // ----------------------------------------------------------------------
    // Readable status, held until clear
    // ----------------------------------------------------------------------
    typedef struct packed {
        // One sticky bit per port that ever faulted
        logic [`OBI_NUM_PORTS-1:0] mask;
        logic                      first_valid;
        // Lowest-numbered port of the first faulting cycle
        logic [`PORT_ID_W-1:0]     first_port;
        // Saturates at all ones
        logic [`FAULT_CNT_W-1:0]   fault_count;
    } alert_status_t;

endpackage

//--- rtl/obi_resp_sampler.sv
// OBI response sampler
// Registers every port once per cycle, disabled ports read as idle bus

`timescale 1ns/1ns

`include "integrity_params.svh"

module obi_resp_sampler (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Level per port, low masks the port
    input  logic [`OBI_NUM_PORTS-1:0] port_en_i,
    input  obi_pkg::obi_sample_t      resp_i [`OBI_NUM_PORTS],
    output obi_pkg::obi_sample_t      sampled_o [`OBI_NUM_PORTS]
);

    // Samples after port masking
    obi_pkg::obi_sample_t masked [`OBI_NUM_PORTS];

    // ----------------------------------------------------------------------
    // Port masking
    // ----------------------------------------------------------------------

    // Disabled port is replaced by a parity-consistent idle value,
    // so its checker sees neither handshakes nor faults
    always_comb begin
        for (int p = 0; p < `OBI_NUM_PORTS; p++) begin
            if (port_en_i[p]) begin
                masked[p] = resp_i[p];
            end else begin
                masked[p] = obi_pkg::OBI_SAMPLE_IDLE;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Sample stage
    // ----------------------------------------------------------------------

    // One flop stage for all ports, first cycle of the 3-cycle latency
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Idle out of reset keeps the checkers quiet
            for (int p = 0; p < `OBI_NUM_PORTS; p++) begin
                sampled_o[p] <= obi_pkg::OBI_SAMPLE_IDLE;
            end
        end else begin
            for (int p = 0; p < `OBI_NUM_PORTS; p++) begin
                sampled_o[p] <= masked[p];
            end
        end
    end

endmodule

//--- rtl/obi_port_checker.sv
// OBI port integrity checker
// Judges parity, rchk and outstanding-request rules for one port

`timescale 1ns/1ns

`include "integrity_params.svh"

module obi_port_checker (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  obi_pkg::obi_sample_t   sample_i,
    output alert_pkg::port_fault_t fault_o
);

    // Expected rchk from rdata and err
    logic [`OBI_RCHK_W-1:0] rchk_exp;
    // Individual rule violations
    logic                   gntpar_bad;
    logic                   rvalidpar_bad;
    logic                   rchk_bad;
    logic                   underflow;
    logic                   overflow;
    logic                   proto_bad;
    // Granted request this cycle
    logic                   accept;
    // Granted requests still waiting for rvalid
    logic [`OBI_OUTST_W-1:0] outst_q;
    alert_pkg::fault_kind_e kind_d;

    // ----------------------------------------------------------------------
    // Integrity checks
    // ----------------------------------------------------------------------

    // Even parity per byte lane, top bit mirrors err
    always_comb begin
        for (int b = 0; b < `OBI_DATA_W / 8; b++) begin
            rchk_exp[b] = ^sample_i.rdata[8*b +: 8];
        end
        rchk_exp[`OBI_RCHK_W-1] = sample_i.err;
    end

    // Parity lines are checked every cycle
    assign gntpar_bad    = (sample_i.gntpar == sample_i.gnt);
    assign rvalidpar_bad = (sample_i.rvalidpar == sample_i.rvalid);
    // rchk only carries meaning alongside rvalid
    assign rchk_bad      = sample_i.rvalid && (sample_i.rchk != rchk_exp);

    // ----------------------------------------------------------------------
    // Outstanding tracking
    // ----------------------------------------------------------------------
    assign accept    = sample_i.req && sample_i.gnt;
    // Response with nothing in flight
    assign underflow = sample_i.rvalid && (outst_q == '0);
    // New grant beyond the limit, a simultaneous rvalid frees a slot
    assign overflow  = accept && !sample_i.rvalid &&
                       (outst_q >= `OBI_OUTST_W'(`OBI_MAX_OUTST));
    assign proto_bad = underflow || overflow;

    // Count holds on a protocol fault
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outst_q <= '0;
        end else if (!proto_bad) begin
            if (accept && !sample_i.rvalid) begin
                outst_q <= outst_q + 1'b1;
            end else if (!accept && sample_i.rvalid) begin
                outst_q <= outst_q - 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Verdict
    // ----------------------------------------------------------------------

    // Highest priority first
    always_comb begin
        if (proto_bad) begin
            kind_d = alert_pkg::FAULT_PROTOCOL;
        end else if (rchk_bad) begin
            kind_d = alert_pkg::FAULT_RCHK;
        end else if (rvalidpar_bad) begin
            kind_d = alert_pkg::FAULT_RVALIDPAR;
        end else if (gntpar_bad) begin
            kind_d = alert_pkg::FAULT_GNTPAR;
        end else begin
            kind_d = alert_pkg::FAULT_NONE;
        end
    end

    // Registered record, second cycle of the latency
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fault_o.kind     <= alert_pkg::FAULT_NONE;
            fault_o.err_resp <= 1'b0;
        end else begin
            fault_o.kind     <= kind_d;
            // Error response only counts when everything else is clean
            fault_o.err_resp <= sample_i.rvalid && sample_i.err &&
                                (kind_d == alert_pkg::FAULT_NONE);
        end
    end

endmodule

//--- rtl/alert_aggregator.sv
// Alert aggregator
// Folds per-port fault records into alert pulses and sticky status

`timescale 1ns/1ns

`include "integrity_params.svh"

module alert_aggregator (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // One-cycle pulse, zeroes the status
    input  logic                     clear_i,
    input  alert_pkg::port_fault_t   fault_i [`OBI_NUM_PORTS],
    output logic                     alert_major_o,
    output logic                     alert_minor_o,
    output alert_pkg::alert_status_t status_o
);

    logic [`OBI_NUM_PORTS-1:0] flt_vec;
    logic [`OBI_NUM_PORTS-1:0] err_vec;
    // Faulting ports this cycle, one bit wider than the counter
    logic [`FAULT_CNT_W:0]     flt_num;
    logic [`FAULT_CNT_W:0]     cnt_sum;
    logic [`PORT_ID_W-1:0]     low_port;
    alert_pkg::alert_status_t  base_status;
    alert_pkg::alert_status_t  status_d;

    // ----------------------------------------------------------------------
    // Per-port reduction
    // ----------------------------------------------------------------------

    // Walk downwards so the last hit is the lowest port
    always_comb begin
        flt_num  = '0;
        low_port = '0;
        for (int p = `OBI_NUM_PORTS - 1; p >= 0; p--) begin
            flt_vec[p] = (fault_i[p].kind != alert_pkg::FAULT_NONE);
            err_vec[p] = fault_i[p].err_resp;
            if (flt_vec[p]) begin
                flt_num  = flt_num + 1'b1;
                low_port = `PORT_ID_W'(p);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Next status
    // ----------------------------------------------------------------------
    always_comb begin
        // Clear first, faults of the same cycle land on the cleared status
        if (clear_i) begin
            base_status = '0;
        end else begin
            base_status = status_o;
        end
        status_d      = base_status;
        status_d.mask = base_status.mask | flt_vec;
        // Saturating add
        cnt_sum = {1'b0, base_status.fault_count} + flt_num;
        if (cnt_sum[`FAULT_CNT_W]) begin
            status_d.fault_count = '1;
        end else begin
            status_d.fault_count = cnt_sum[`FAULT_CNT_W-1:0];
        end
        // First fault capture
        if (!base_status.first_valid && (|flt_vec)) begin
            status_d.first_valid = 1'b1;
            status_d.first_port  = low_port;
        end
    end

    // Third cycle of the latency, alerts are single-cycle pulses
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alert_major_o <= 1'b0;
            alert_minor_o <= 1'b0;
            status_o      <= '0;
        end else begin
            alert_major_o <= |flt_vec;
            alert_minor_o <= |err_vec;
            status_o      <= status_d;
        end
    end

endmodule

//--- rtl/obi_integrity_top.sv
// OBI response-integrity monitor top
// Sampler, one checker per port and the alert aggregator

`timescale 1ns/1ns

`include "integrity_params.svh"

module obi_integrity_top (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [`OBI_NUM_PORTS-1:0] port_en_i,
    input  obi_pkg::obi_sample_t      resp_i [`OBI_NUM_PORTS],
    input  logic                      clear_i,
    output logic                      alert_major_o,
    output logic                      alert_minor_o,
    output alert_pkg::alert_status_t  status_o
);

    // Registered port samples
    obi_pkg::obi_sample_t   sampled [`OBI_NUM_PORTS];
    // Per-port verdicts
    alert_pkg::port_fault_t fault [`OBI_NUM_PORTS];

    // ----------------------------------------------------------------------
    // Stage 1, sample and mask
    // ----------------------------------------------------------------------
    obi_resp_sampler sampler_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .port_en_i (port_en_i),
        .resp_i    (resp_i),
        .sampled_o (sampled)
    );

    // ----------------------------------------------------------------------
    // Stage 2, one checker per port
    // ----------------------------------------------------------------------
    for (genvar k = 0; k < `OBI_NUM_PORTS; k++) begin : chk_g
        obi_port_checker checker_i (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .sample_i (sampled[k]),
            .fault_o  (fault[k])
        );
    end

    // ----------------------------------------------------------------------
    // Stage 3, alerts and status
    // ----------------------------------------------------------------------
    alert_aggregator aggregator_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .clear_i       (clear_i),
        .fault_i       (fault),
        .alert_major_o (alert_major_o),
        .alert_minor_o (alert_minor_o),
        .status_o      (status_o)
    );

endmodule

//--- bench/obi_integrity_chk.sv
// Alert aggregator assertions
// Quiet alerts in reset, monotonic fault count, sticky first fault

`timescale 1ns/1ns

`include "integrity_params.svh"

module obi_integrity_chk (
    input logic                     clk_i,
    input logic                     arst_n_i,
    input logic                     clear_i,
    input logic                     alert_major_i,
    input logic                     alert_minor_i,
    input alert_pkg::alert_status_t status_i
);

    // Number of failed assertions
    int fail_cnt = 0;

    // No alert while reset is held
    quiet_in_reset_a : assert property (@(posedge clk_i)
        !arst_n_i |-> (!alert_major_i && !alert_minor_i))
        else begin
            $error("Alert high during reset");
            fail_cnt++;
        end

    // Count only falls through a clear
    count_monotonic_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$past(clear_i) |-> (status_i.fault_count >= $past(status_i.fault_count)))
        else begin
            $error("fault_count decreased without clear");
            fail_cnt++;
        end

    // First fault record is held until cleared
    first_sticky_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ($past(status_i.first_valid) && !$past(clear_i)) |-> status_i.first_valid)
        else begin
            $error("first_valid dropped without clear");
            fail_cnt++;
        end

endmodule

bind alert_aggregator obi_integrity_chk chk_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .clear_i       (clear_i),
    .alert_major_i (alert_major_o),
    .alert_minor_i (alert_minor_o),
    .status_i      (status_o)
);

//--- bench/obi_integrity_tb.sv
// OBI integrity monitor testbench
// Replays stimulus records and compares alerts and status after the pipeline

`timescale 1ns/1ns

`include "integrity_params.svh"

module obi_integrity_tb;

    // One stimulus line, the data file always carries two ports
    typedef struct packed {
        logic [`OBI_NUM_PORTS-1:0]  en;
        logic                       clr;
        obi_pkg::obi_sample_t [1:0] smp;
        logic                       major;
        logic                       minor;
        alert_pkg::alert_status_t   status;
    } record_t;

    logic                     clk_i;
    logic                     arst_n_i;
    logic [`OBI_NUM_PORTS-1:0] port_en_i;
    logic                     clear_i;
    obi_pkg::obi_sample_t     resp_i [`OBI_NUM_PORTS];
    logic                     alert_major_o;
    logic                     alert_minor_o;
    alert_pkg::alert_status_t status_o;

    record_t recs [$];
    int      cycle_cnt   = 0;
    int      cycle_limit = 64;

    obi_integrity_top dut_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .port_en_i     (port_en_i),
        .resp_i        (resp_i),
        .clear_i       (clear_i),
        .alert_major_o (alert_major_o),
        .alert_minor_o (alert_minor_o),
        .status_o      (status_o)
    );

    // 20 ns period
    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // Watchdog, limit set once the records are loaded
    // ----------------------------------------------------------------------
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Watch the assertions bound to the aggregator
    always @(dut_i.aggregator_i.chk_i.fail_cnt) begin
        if (dut_i.aggregator_i.chk_i.fail_cnt != 0) begin
            $display("An assertion on the alert aggregator failed");
            $display("CHECKS FAILED");
            $fatal(1, "Assertion failure");
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Quiet bus, parity lines are the inverse of low gnt and rvalid
    function automatic obi_pkg::obi_sample_t idle_sample();
        obi_pkg::obi_sample_t s;
        s           = '0;
        s.gntpar    = 1'b1;
        s.rvalidpar = 1'b1;
        return s;
    endfunction

    // Eight file columns starting at base make one port sample
    function automatic obi_pkg::obi_sample_t make_sample(input logic [31:0] c [24],
                                                         input int base);
        obi_pkg::obi_sample_t s;
        s.req       = c[base][0];
        s.gnt       = c[base+1][0];
        s.gntpar    = c[base+2][0];
        s.rvalid    = c[base+3][0];
        s.rvalidpar = c[base+4][0];
        s.rdata     = c[base+5];
        s.err       = c[base+6][0];
        s.rchk      = c[base+7][`OBI_RCHK_W-1:0];
        return s;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "Stimulus problem");
    endtask

    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [24];
        record_t     rec;
        fd = $fopen("bench/obi_integrity_stim.txt", "r");
        if (fd == 0) begin
            stop_on_error("Cannot open bench/obi_integrity_stim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                        f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23]);
            if (n != 24) begin
                stop_on_error($sformatf("Malformed stimulus line: %s", line));
            end
            rec.en                 = f[0][`OBI_NUM_PORTS-1:0];
            rec.clr                = f[1][0];
            rec.smp[0]             = make_sample(f, 2);
            rec.smp[1]             = make_sample(f, 10);
            rec.major              = f[18][0];
            rec.minor              = f[19][0];
            rec.status.mask        = f[20][`OBI_NUM_PORTS-1:0];
            rec.status.first_valid = f[21][0];
            rec.status.first_port  = f[22][`PORT_ID_W-1:0];
            rec.status.fault_count = f[23][`FAULT_CNT_W-1:0];
            recs.push_back(rec);
        end
        $fclose(fd);
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "Output mismatch");
    endtask

    task automatic check_alerts(input logic got_major, input logic got_minor,
                                input logic exp_major, input logic exp_minor, input int idx);
        if (got_major !== exp_major) begin
            report_mismatch($sformatf("record %0d alert_major_o got %b expected %b",
                                      idx, got_major, exp_major));
        end
        if (got_minor !== exp_minor) begin
            report_mismatch($sformatf("record %0d alert_minor_o got %b expected %b",
                                      idx, got_minor, exp_minor));
        end
    endtask

    task automatic check_status(input alert_pkg::alert_status_t got,
                                input alert_pkg::alert_status_t exp, input int idx);
        if (got.mask !== exp.mask) begin
            report_mismatch($sformatf("record %0d mask got %h expected %h",
                                      idx, got.mask, exp.mask));
        end
        if (got.first_valid !== exp.first_valid) begin
            report_mismatch($sformatf("record %0d first_valid got %b expected %b",
                                      idx, got.first_valid, exp.first_valid));
        end
        if (got.first_port !== exp.first_port) begin
            report_mismatch($sformatf("record %0d first_port got %0d expected %0d",
                                      idx, got.first_port, exp.first_port));
        end
        if (got.fault_count !== exp.fault_count) begin
            report_mismatch($sformatf("record %0d fault_count got %0d expected %0d",
                                      idx, got.fault_count, exp.fault_count));
        end
    endtask

    task automatic drive_idle();
        clear_i = 1'b0;
        for (int p = 0; p < `OBI_NUM_PORTS; p++) begin
            resp_i[p] = idle_sample();
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        arst_n_i  = 1'b0;
        port_en_i = '1;
        drive_idle();
        load_records();
        // Record slot is 4 cycles, margin covers reset
        cycle_limit = 4 * recs.size() + 64;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        foreach (recs[i]) begin
            @(negedge clk_i);
            port_en_i = recs[i].en;
            clear_i   = recs[i].clr;
            resp_i[0] = recs[i].smp[0];
            resp_i[1] = recs[i].smp[1];
            @(negedge clk_i);
            drive_idle();
            @(negedge clk_i);
            // Third edge after the record has now passed
            @(negedge clk_i);
            check_alerts(alert_major_o, alert_minor_o, recs[i].major, recs[i].minor, i);
            check_status(status_o, recs[i].status, i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- bench/obi_integrity_stim.txt
# en clr | p0: req gnt gntpar rvalid rvalidpar rdata err rchk | p1: same eight columns
# expected: major minor mask first_valid first_port fault_count (all hex)
3 0 1 1 0 0 1 00000000 0 00 1 1 0 0 1 00000000 0 00 0 0 0 0 0 00
3 0 0 0 1 1 0 01020304 0 0d 0 0 1 1 0 12345678 0 04 0 0 0 0 0 00
3 0 1 1 0 0 1 00000000 0 00 0 0 1 0 1 00000000 0 00 0 0 0 0 0 00
3 0 0 0 1 1 0 deadbeef 1 15 0 0 1 0 1 00000000 0 00 0 1 0 0 0 00
3 0 0 0 1 0 1 00000000 0 00 0 0 0 0 1 00000000 0 00 1 0 2 1 1 01
3 0 0 0 1 0 0 00000000 0 00 0 0 1 0 1 00000000 0 00 1 0 3 1 1 02
3 0 0 0 1 0 1 00000000 0 00 1 1 0 0 1 00000000 0 00 0 0 3 1 1 02
3 0 0 0 1 0 1 00000000 0 00 0 0 1 1 0 01020304 0 0c 1 0 3 1 1 03
3 1 0 0 1 1 0 00000000 0 00 0 0 1 0 1 00000000 0 00 1 0 1 1 0 01
3 0 1 1 0 0 1 00000000 0 00 0 0 1 0 1 00000000 0 00 0 0 1 1 0 01
3 0 1 1 0 0 1 00000000 0 00 0 0 1 0 1 00000000 0 00 0 0 1 1 0 01
3 0 1 1 0 0 1 00000000 0 00 0 0 1 0 1 00000000 0 00 1 0 1 1 0 02
3 1 0 0 0 0 1 00000000 0 00 0 0 1 0 0 00000000 0 00 1 0 3 1 0 02
3 0 0 0 1 0 1 00000000 0 00 0 0 0 0 1 00000000 0 00 1 0 3 1 0 03
1 0 0 0 1 0 1 00000000 0 00 1 1 1 1 1 12345678 0 1f 0 0 3 1 0 03
3 1 0 0 1 0 1 00000000 0 00 0 0 1 0 1 00000000 0 00 0 0 0 0 0 00
3 0 0 0 1 1 0 12345678 0 04 0 0 1 0 1 00000000 0 00 0 0 0 0 0 00

//--- obi_integrity_top.f
+incdir+include
rtl/obi_pkg.sv
rtl/alert_pkg.sv
rtl/obi_resp_sampler.sv
rtl/obi_port_checker.sv
rtl/alert_aggregator.sv
rtl/obi_integrity_top.sv
bench/obi_integrity_chk.sv
bench/obi_integrity_tb.sv

//--- Makefile
# Verilator build and run of the OBI integrity monitor testbench

VERILATOR ?= verilator
TOP       := obi_integrity_tb
FILELIST  := obi_integrity_top.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
STIM      := bench/obi_integrity_stim.txt

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM) $(STIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
